//--- include/sys_bus_consts.svh
`ifndef SYS_BUS_CONSTS_SVH
`define SYS_BUS_CONSTS_SVH

// ============================================================
// address map
// ============================================================

// boot rom spans page 00 up to this offset
`define BOOT_TOP      8'hFF
`define IO_PAGE       8'hFF

// high ram window inside the io page
`define HRAM_LO       8'h80
`define HRAM_HI       8'hFE

// ============================================================
// io register offsets
// ============================================================
`define OFF_TIMER_LO  8'h04
`define OFF_TIMER_HI  8'h07
`define OFF_IF        8'h0F
`define OFF_BOOT      8'h50
`define OFF_TEST      8'h60

// pull-up value seen when nothing drives the bus
`define IDLE_BYTE     8'hFF

`endif

//--- design/sys_bus_pkg.sv
package sys_bus_pkg;

	// io view of an address
	typedef struct packed {
		logic [7:0] page;
		logic [7:0] offset;
	} gb_addr_fields_s;

	// same 16 bits, flat for range compares
	typedef union packed {
		logic [15:0]     raw;
		gb_addr_fields_s io;
	} gb_addr_u;

	// ============================================================
	// decoded regions
	// ============================================================
	typedef enum logic [2:0] {
		REG_BOOT  = 3'd0,
		REG_HRAM  = 3'd1,
		// ff50 and ff60, held on chip
		REG_IOINT = 3'd2,
		REG_IOEXT = 3'd3,
		REG_EXT   = 3'd4
	} region_e;

endpackage

//--- design/bus_capture.sv
`timescale 1ns/1ps

module bus_capture import sys_bus_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        t1,
	input  logic        t2,
	input  logic [15:0] cpu_addr,
	input  logic        cpu_rd,
	input  logic        cpu_wr,
	input  logic [7:0]  cpu_wdata,
	input  logic        ext_rd,
	input  logic        ext_wr,
	output gb_addr_u    cyc_addr,
	output logic        cyc_rd,
	output logic        cyc_wr,
	output logic [7:0]  cyc_wdata,
	output logic        test_mode
);

	logic ext_strobes;
	logic rd_sel;
	logic wr_sel;

	// t1 low with t2 high hands the strobes to the pins
	assign ext_strobes = !t1 && t2;
	assign rd_sel      = ext_strobes ? ext_rd : cpu_rd;
	assign wr_sel      = ext_strobes ? ext_wr : cpu_wr;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cyc_rd    <= 1'b0;
			cyc_wr    <= 1'b0;
			test_mode <= 1'b0;
		end else begin
			// read and write together counts as no access
			cyc_rd    <= rd_sel && !wr_sel;
			cyc_wr    <= wr_sel && !rd_sel;
			test_mode <= t1 || t2;
		end
	end

	// address and data only matter under a strobe
	always_ff @(posedge clk) begin
		cyc_addr.raw <= cpu_addr;
		cyc_wdata    <= cpu_wdata;
	end

endmodule

//--- design/addr_decode.sv
`timescale 1ns/1ps
`include "sys_bus_consts.svh"

module addr_decode import sys_bus_pkg::*; (
	input  gb_addr_u cyc_addr,
	input  logic     cyc_rd,
	input  logic     cyc_wr,
	input  logic     test_mode,
	input  logic     boot_off,
	output region_e  region,
	output logic     boot_cs,
	output logic     hram_cs,
	output logic     timer_cs,
	output logic     if_rd,
	output logic     if_wr,
	output logic     ext_cs,
	output logic     boot_we,
	output logic     test_we
);

	logic access;
	logic io_page;
	logic is_timer;
	logic is_if;
	logic is_boot_reg;
	logic is_test_reg;

	assign access  = cyc_rd || cyc_wr;
	assign io_page = cyc_addr.io.page == `IO_PAGE;

	// ============================================================
	// io register hits
	// ============================================================
	assign is_timer    = io_page && cyc_addr.io.offset >= `OFF_TIMER_LO &&
		cyc_addr.io.offset <= `OFF_TIMER_HI;
	assign is_if       = io_page && cyc_addr.io.offset == `OFF_IF;
	assign is_boot_reg = io_page && cyc_addr.io.offset == `OFF_BOOT;
	assign is_test_reg = io_page && cyc_addr.io.offset == `OFF_TEST;

	// ============================================================
	// region
	// ============================================================
	always_comb begin
		if (cyc_addr.raw <= {8'h00, `BOOT_TOP} && !boot_off && !test_mode) begin
			region = REG_BOOT;
		end else if (cyc_addr.raw >= {`IO_PAGE, `HRAM_LO} &&
			cyc_addr.raw <= {`IO_PAGE, `HRAM_HI}) begin
			region = REG_HRAM;
		end else if (is_boot_reg || is_test_reg) begin
			region = REG_IOINT;
		end else if (io_page) begin
			// ffff and the timer land here too
			region = REG_IOEXT;
		end else begin
			region = REG_EXT;
		end
	end

	// selects only while a strobe is up
	assign boot_cs  = access && region == REG_BOOT;
	assign hram_cs  = access && region == REG_HRAM;
	assign ext_cs   = access && (region == REG_EXT || region == REG_IOEXT);
	assign timer_cs = access && is_timer;
	assign if_rd    = cyc_rd && is_if;
	assign if_wr    = cyc_wr && is_if;

	// test bits are locked outside test mode
	assign boot_we  = cyc_wr && is_boot_reg;
	assign test_we  = cyc_wr && is_test_reg && test_mode;

endmodule

//--- design/boot_ctrl.sv
`timescale 1ns/1ps

module boot_ctrl (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       boot_we,
	input  logic       test_we,
	input  logic [7:0] cyc_wdata,
	output logic       boot_off,
	output logic [1:0] test_bits
);

	logic boot_off_nxt;
	logic [1:0] test_bits_nxt;

	// ============================================================
	// ff50 boot disable
	// ============================================================

	// sticky once set, a zero write leaves it alone
	assign boot_off_nxt = boot_off || (boot_we && cyc_wdata[0]);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			boot_off <= 1'b0;
		end else begin
			boot_off <= boot_off_nxt;
		end
	end

	// ============================================================
	// ff60 factory test bits
	// ============================================================
	always_comb begin
		test_bits_nxt = test_bits;
		if (test_we) begin
			test_bits_nxt = cyc_wdata[1:0];
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			test_bits <= 2'b00;
		end else begin
			test_bits <= test_bits_nxt;
		end
	end

endmodule

//--- design/rdata_return.sv
`timescale 1ns/1ps
`include "sys_bus_consts.svh"

module rdata_return import sys_bus_pkg::*; (
	input  gb_addr_u   cyc_addr,
	input  logic       cyc_rd,
	input  region_e    region,
	input  logic       boot_off,
	input  logic [1:0] test_bits,
	input  logic [7:0] boot_rdata,
	input  logic [7:0] hram_rdata,
	input  logic [7:0] ext_rdata,
	output logic [7:0] cpu_rdata
);

	localparam logic [7:0] IDLE = `IDLE_BYTE;

	logic [7:0] ioint_rdata;

	// unused bits of ff50 and ff60 float high
	always_comb begin
		if (cyc_addr.io.offset == `OFF_BOOT) begin
			ioint_rdata = {IDLE[7:1], boot_off};
		end else begin
			ioint_rdata = {IDLE[7:2], test_bits};
		end
	end

	// ============================================================
	// read mux
	// ============================================================
	always_comb begin
		cpu_rdata = IDLE;
		if (cyc_rd) begin
			case (region)
				REG_BOOT:  cpu_rdata = boot_rdata;
				REG_HRAM:  cpu_rdata = hram_rdata;
				REG_IOINT: cpu_rdata = ioint_rdata;
				REG_IOEXT: cpu_rdata = ext_rdata;
				REG_EXT:   cpu_rdata = ext_rdata;
				default:   cpu_rdata = IDLE;
			endcase
		end
	end

endmodule

//--- design/sys_decode_top.sv
`timescale 1ns/1ps

module sys_decode_top import sys_bus_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        t1,
	input  logic        t2,
	input  logic [15:0] cpu_addr,
	input  logic        cpu_rd,
	input  logic        cpu_wr,
	input  logic [7:0]  cpu_wdata,
	input  logic        ext_rd,
	input  logic        ext_wr,
	input  logic [7:0]  boot_rdata,
	input  logic [7:0]  hram_rdata,
	input  logic [7:0]  ext_rdata,
	output logic        boot_cs,
	output logic        hram_cs,
	output logic        timer_cs,
	output logic        if_rd,
	output logic        if_wr,
	output logic        ext_cs,
	output logic [7:0]  cpu_rdata,
	output logic [1:0]  test_bits,
	output logic        boot_off
);

	gb_addr_u   cyc_addr;
	logic       cyc_rd;
	logic       cyc_wr;
	logic [7:0] cyc_wdata;
	logic       test_mode;
	region_e    region;
	logic       boot_we;
	logic       test_we;

	// input side
	bus_capture u_bus_capture (
		.clk, .arst_n, .t1, .t2,
		.cpu_addr, .cpu_rd, .cpu_wr, .cpu_wdata,
		.ext_rd, .ext_wr,
		.cyc_addr, .cyc_rd, .cyc_wr, .cyc_wdata, .test_mode
	);

	addr_decode u_addr_decode (
		.cyc_addr, .cyc_rd, .cyc_wr, .test_mode, .boot_off,
		.region, .boot_cs, .hram_cs, .timer_cs,
		.if_rd, .if_wr, .ext_cs, .boot_we, .test_we
	);

	boot_ctrl u_boot_ctrl (
		.clk, .arst_n, .boot_we, .test_we, .cyc_wdata,
		.boot_off, .test_bits
	);

	// output side
	rdata_return u_rdata_return (
		.cyc_addr, .cyc_rd, .region, .boot_off, .test_bits,
		.boot_rdata, .hram_rdata, .ext_rdata,
		.cpu_rdata
	);

endmodule

//--- dv/sys_decode_checker.sv
`timescale 1ns/1ps

module sys_decode_checker (
	input logic       clk,
	input logic       arst_n,
	input logic       boot_cs,
	input logic       hram_cs,
	input logic       ext_cs,
	input logic       boot_off,
	input logic [1:0] test_bits,
	input logic       test_mode
);

	int fail_cnt = 0;

	// one memory side per access
	sel_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0({boot_cs, hram_cs, ext_cs}))
		else begin
			$error("boot_cs, hram_cs and ext_cs active together");
			fail_cnt++;
		end

	boot_off_sticky: assert property (@(posedge clk) disable iff (!arst_n)
		!$fell(boot_off))
		else begin
			$error("boot_off cleared outside reset");
			fail_cnt++;
		end

	// ff60 locked in normal mode
	test_bits_locked: assert property (@(posedge clk) disable iff (!arst_n)
		!test_mode |=> $stable(test_bits))
		else begin
			$error("test_bits changed after a normal mode cycle");
			fail_cnt++;
		end

endmodule

bind sys_decode_top sys_decode_checker chk (
	.clk, .arst_n, .boot_cs, .hram_cs, .ext_cs, .boot_off, .test_bits, .test_mode
);

//--- dv/sys_decode_monitor.sv
`timescale 1ns/1ps

module sys_decode_monitor (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       exp_valid,
	input  int         exp_test,
	input  logic [5:0] exp_sel,
	input  logic [7:0] exp_rdata,
	input  logic       exp_boot_off,
	input  logic [1:0] exp_test_bits,
	input  logic       boot_cs,
	input  logic       hram_cs,
	input  logic       timer_cs,
	input  logic       if_rd,
	input  logic       if_wr,
	input  logic       ext_cs,
	input  logic [7:0] cpu_rdata,
	input  logic       boot_off,
	input  logic [1:0] test_bits,
	output logic       busy,
	output int         errors
);

	logic       v1;
	logic       v2;
	int         p1_test;
	int         p2_test;
	logic [5:0] p1_sel;
	logic [7:0] p1_rdata;
	logic       p1_boff;
	logic       p2_boff;
	logic [1:0] p1_tbits;
	logic [1:0] p2_tbits;
	int         s1_errs = 0;
	int         p2_errs;
	int         cur_test = -1;
	int         cur_lines = 0;
	int         cur_errs = 0;
	int         tests_done = 0;
	int         tests_failed = 0;
	int         lines_done = 0;

	initial errors = 0;

	assign busy = v1 || v2;

	task automatic compare_field(input string name, input logic [7:0] got,
		input logic [7:0] want, inout int cnt);
		if (got !== want) begin
			$display("** Error at %0t: %s is %h, expected %h", $time, name, got, want);
			cnt++;
		end
	endtask

	task automatic finish_test();
		if (cur_lines > 0) begin
			if (cur_errs == 0) begin
				$display("test %0d passed, %0d accesses", cur_test, cur_lines);
			end else begin
				$display("test %0d failed, %0d mismatches in %0d accesses",
					cur_test, cur_errs, cur_lines);
				tests_failed++;
			end
			tests_done++;
		end
		cur_lines = 0;
		cur_errs  = 0;
	endtask

	task automatic close_report();
		finish_test();
		$display("%0d tests, %0d failed, %0d accesses checked, %0d mismatches",
			tests_done, tests_failed, lines_done, errors);
	endtask

	// ============================================================
	// expected values follow the access through the dut
	// ============================================================
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			v1 <= 1'b0;
			v2 <= 1'b0;
		end else begin
			v1       <= exp_valid;
			p1_test  <= exp_test;
			p1_sel   <= exp_sel;
			p1_rdata <= exp_rdata;
			p1_boff  <= exp_boot_off;
			p1_tbits <= exp_test_bits;
			v2       <= v1;
			p2_test  <= p1_test;
			p2_boff  <= p1_boff;
			p2_tbits <= p1_tbits;
			p2_errs  <= s1_errs;
		end
	end

	// selects one cycle after drive, registers one more
	always @(negedge clk) begin
		int line_errs;

		if (v1) begin
			s1_errs = 0;
			compare_field("boot_cs", boot_cs, p1_sel[5], s1_errs);
			compare_field("hram_cs", hram_cs, p1_sel[4], s1_errs);
			compare_field("timer_cs", timer_cs, p1_sel[3], s1_errs);
			compare_field("if_rd", if_rd, p1_sel[2], s1_errs);
			compare_field("if_wr", if_wr, p1_sel[1], s1_errs);
			compare_field("ext_cs", ext_cs, p1_sel[0], s1_errs);
			compare_field("cpu_rdata", cpu_rdata, p1_rdata, s1_errs);
		end
		if (v2) begin
			line_errs = p2_errs;
			compare_field("boot_off", boot_off, p2_boff, line_errs);
			compare_field("test_bits", test_bits, p2_tbits, line_errs);
			if (p2_test != cur_test) begin
				finish_test();
				cur_test = p2_test;
			end
			cur_lines++;
			cur_errs += line_errs;
			lines_done++;
			errors += line_errs;
		end
	end

endmodule

//--- dv/sys_decode_tb.sv
`timescale 1ns/1ps

module sys_decode_tb;

	localparam int RESET_CYCLES = 3;
	localparam int DRAIN_CYCLES = 20;
	localparam int STIM_FIELDS  = 21;

	logic        clk;
	logic        arst_n;
	logic        t1;
	logic        t2;
	logic [15:0] cpu_addr;
	logic        cpu_rd;
	logic        cpu_wr;
	logic [7:0]  cpu_wdata;
	logic        ext_rd;
	logic        ext_wr;
	logic [7:0]  boot_rdata;
	logic [7:0]  hram_rdata;
	logic [7:0]  ext_rdata;
	logic        boot_cs;
	logic        hram_cs;
	logic        timer_cs;
	logic        if_rd;
	logic        if_wr;
	logic        ext_cs;
	logic [7:0]  cpu_rdata;
	logic [1:0]  test_bits;
	logic        boot_off;

	logic        exp_valid;
	int          exp_test;
	logic [5:0]  exp_sel;
	logic [7:0]  exp_rdata;
	logic        exp_boot_off;
	logic [1:0]  exp_test_bits;
	logic        mon_busy;
	int          mon_errors;
	int          stim_errors;
	int          applied;

	// memory side answers one cycle after the access is driven
	logic [7:0]  next_boot;
	logic [7:0]  next_hram;
	logic [7:0]  next_ext;

	initial clk = 1'b0;
	always #5 clk = ~clk;

	sys_decode_top dut (
		.clk, .arst_n, .t1, .t2,
		.cpu_addr, .cpu_rd, .cpu_wr, .cpu_wdata,
		.ext_rd, .ext_wr,
		.boot_rdata, .hram_rdata, .ext_rdata,
		.boot_cs, .hram_cs, .timer_cs, .if_rd, .if_wr, .ext_cs,
		.cpu_rdata, .test_bits, .boot_off
	);

	sys_decode_monitor mon (
		.clk, .arst_n,
		.exp_valid, .exp_test, .exp_sel, .exp_rdata, .exp_boot_off, .exp_test_bits,
		.boot_cs, .hram_cs, .timer_cs, .if_rd, .if_wr, .ext_cs,
		.cpu_rdata, .boot_off, .test_bits,
		.busy(mon_busy),
		.errors(mon_errors)
	);

	// no access on the bus, memory bytes still follow the last one
	task automatic drive_idle();
		t1         = 1'b0;
		t2         = 1'b0;
		cpu_addr   = 16'h0000;
		cpu_rd     = 1'b0;
		cpu_wr     = 1'b0;
		cpu_wdata  = 8'h00;
		ext_rd     = 1'b0;
		ext_wr     = 1'b0;
		boot_rdata = next_boot;
		hram_rdata = next_hram;
		ext_rdata  = next_ext;
		exp_valid  = 1'b0;
	endtask

	initial begin
		int          fd;
		int          n;
		int          waited;
		int          total;
		string       line;
		int          tnum;
		logic        s_t1;
		logic        s_t2;
		logic        s_rd;
		logic        s_wr;
		logic        s_erd;
		logic        s_ewr;
		logic [15:0] s_addr;
		logic [7:0]  s_wdata;
		logic [7:0]  s_boot;
		logic [7:0]  s_hram;
		logic [7:0]  s_ext;
		logic        e_bcs;
		logic        e_hcs;
		logic        e_tcs;
		logic        e_ifr;
		logic        e_ifw;
		logic        e_xcs;
		logic [7:0]  e_rdata;
		logic        e_boff;
		logic [1:0]  e_tbits;

		next_boot     = 8'hFF;
		next_hram     = 8'hFF;
		next_ext      = 8'hFF;
		exp_test      = 0;
		exp_sel       = 6'b0;
		exp_rdata     = 8'hFF;
		exp_boot_off  = 1'b0;
		exp_test_bits = 2'b00;
		stim_errors   = 0;
		applied       = 0;
		drive_idle();
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		arst_n = 1'b1;

		fd = $fopen("dv/sys_decode_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open dv/sys_decode_stim.txt");
			stim_errors++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() < 2 || line.getc(0) == "#") begin
					continue;
				end
				n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					tnum, s_t1, s_t2, s_rd, s_wr, s_erd, s_ewr, s_addr, s_wdata,
					s_boot, s_hram, s_ext, e_bcs, e_hcs, e_tcs, e_ifr, e_ifw, e_xcs,
					e_rdata, e_boff, e_tbits);
				if (n != STIM_FIELDS) begin
					$display("stim line could not be parsed: %s", line);
					stim_errors++;
					continue;
				end
				@(posedge clk);
				#1;
				t1            = s_t1;
				t2            = s_t2;
				cpu_addr      = s_addr;
				cpu_rd        = s_rd;
				cpu_wr        = s_wr;
				cpu_wdata     = s_wdata;
				ext_rd        = s_erd;
				ext_wr        = s_ewr;
				boot_rdata    = next_boot;
				hram_rdata    = next_hram;
				ext_rdata     = next_ext;
				next_boot     = s_boot;
				next_hram     = s_hram;
				next_ext      = s_ext;
				exp_valid     = 1'b1;
				exp_test      = tnum;
				exp_sel       = {e_bcs, e_hcs, e_tcs, e_ifr, e_ifw, e_xcs};
				exp_rdata     = e_rdata;
				exp_boot_off  = e_boff;
				exp_test_bits = e_tbits;
				applied++;
			end
			$fclose(fd);
			if (applied == 0) begin
				$display("no accesses were read from the stim file");
				stim_errors++;
			end
		end

		// ============================================================
		// drain the monitor pipeline
		// ============================================================
		@(posedge clk);
		#1;
		drive_idle();
		waited = 0;
		while (mon_busy && waited < DRAIN_CYCLES) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (mon_busy) begin
			$display("timed out waiting for the monitor to finish its checks");
			stim_errors++;
		end

		mon.close_report();
		if (dut.chk.fail_cnt != 0) begin
			$display("%0d assertion failures in the bus checker", dut.chk.fail_cnt);
		end
		total = mon_errors + stim_errors + dut.chk.fail_cnt;
		if (total == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- dv/sys_decode_stim.txt
# test t1 t2 rd wr ext_rd ext_wr addr wdata boot_byte hram_byte ext_byte, then expected:
# boot_cs hram_cs timer_cs if_rd if_wr ext_cs cpu_rdata boot_off test_bits
1 0 0 1 0 0 0 0000 00 b1 51 e1  1 0 0 0 0 0 b1 0 0
1 0 0 1 0 0 0 00ff 00 b2 52 e2  1 0 0 0 0 0 b2 0 0
1 0 0 1 0 0 0 0100 00 b3 53 e3  0 0 0 0 0 1 e3 0 0
1 0 0 1 0 0 0 ff7f 00 b4 54 e4  0 0 0 0 0 1 e4 0 0
1 0 0 1 0 0 0 ff80 00 b5 55 e5  0 1 0 0 0 0 55 0 0
1 0 0 1 0 0 0 fffe 00 b6 56 e6  0 1 0 0 0 0 56 0 0
1 0 0 1 0 0 0 ffff 00 b7 57 e7  0 0 0 0 0 1 e7 0 0
1 0 0 0 1 0 0 0000 a5 b8 58 e8  1 0 0 0 0 0 ff 0 0
1 0 0 0 1 0 0 8000 a5 b9 59 e9  0 0 0 0 0 1 ff 0 0
2 0 0 1 0 0 0 ff03 00 b1 51 c1  0 0 0 0 0 1 c1 0 0
2 0 0 1 0 0 0 ff04 00 b1 51 c2  0 0 1 0 0 1 c2 0 0
2 0 0 0 1 0 0 ff07 12 b1 51 c3  0 0 1 0 0 1 ff 0 0
2 0 0 1 0 0 0 ff08 00 b1 51 c4  0 0 0 0 0 1 c4 0 0
2 0 0 1 0 0 0 ff0f 00 b1 51 c5  0 0 0 1 0 1 c5 0 0
2 0 0 0 1 0 0 ff0f 1f b1 51 c6  0 0 0 0 1 1 ff 0 0
2 0 0 0 0 0 0 ff04 00 b1 51 c7  0 0 0 0 0 0 ff 0 0
3 0 1 1 0 0 0 0000 00 b1 51 d1  0 0 0 0 0 0 ff 0 0
3 0 1 0 0 1 0 0000 00 b1 51 d2  0 0 0 0 0 1 d2 0 0
3 0 1 0 0 0 1 ff80 33 b1 51 d3  0 1 0 0 0 0 ff 0 0
3 0 1 0 1 0 0 ff80 33 b1 51 d4  0 0 0 0 0 0 ff 0 0
3 0 1 0 0 1 1 ff80 00 b1 51 d5  0 0 0 0 0 0 ff 0 0
3 1 0 1 0 0 0 0010 00 b1 51 d6  0 0 0 0 0 1 d6 0 0
3 1 0 0 0 1 0 0010 00 b1 51 d7  0 0 0 0 0 0 ff 0 0
3 1 1 1 0 0 0 ff80 00 b1 58 d8  0 1 0 0 0 0 58 0 0
3 0 0 1 0 0 0 0010 00 ba 51 d9  1 0 0 0 0 0 ba 0 0
4 0 0 0 1 0 0 ff60 03 b1 51 e1  0 0 0 0 0 0 ff 0 0
4 0 0 1 0 0 0 ff60 00 b1 51 e1  0 0 0 0 0 0 fc 0 0
4 1 0 0 1 0 0 ff60 f2 b1 51 e1  0 0 0 0 0 0 ff 0 2
4 1 0 1 0 0 0 ff60 00 b1 51 e1  0 0 0 0 0 0 fe 0 2
4 0 1 0 0 0 1 ff60 fd b1 51 e1  0 0 0 0 0 0 ff 0 1
4 0 0 1 0 0 0 ff60 00 b1 51 e1  0 0 0 0 0 0 fd 0 1
4 0 0 0 1 0 0 ff60 00 b1 51 e1  0 0 0 0 0 0 ff 0 1
5 0 0 1 0 0 0 0050 00 c0 51 e1  1 0 0 0 0 0 c0 0 1
5 0 0 1 0 0 0 ff50 00 c0 51 e1  0 0 0 0 0 0 fe 0 1
5 0 0 0 1 0 0 ff50 fe c0 51 e1  0 0 0 0 0 0 ff 0 1
5 0 0 1 0 0 0 0050 00 c1 51 e1  1 0 0 0 0 0 c1 0 1
5 0 0 0 1 0 0 ff50 01 c1 51 e1  0 0 0 0 0 0 ff 1 1
5 0 0 1 0 0 0 0050 00 c2 51 e2  0 0 0 0 0 1 e2 1 1
5 0 0 0 1 0 0 ff50 00 c2 51 e2  0 0 0 0 0 0 ff 1 1
5 0 0 1 0 0 0 ff50 00 c2 51 e2  0 0 0 0 0 0 ff 1 1
5 0 0 1 0 0 0 00ff 00 c3 51 e3  0 0 0 0 0 1 e3 1 1
6 0 0 1 0 0 0 ffc0 00 c0 6a 7e  0 1 0 0 0 0 6a 1 1
6 0 0 1 0 0 0 c000 00 c0 6a 7f  0 0 0 0 0 1 7f 1 1
6 0 0 1 0 0 0 ff40 00 c0 6a 70  0 0 0 0 0 1 70 1 1
6 0 0 1 0 0 0 ff60 00 c0 6a 70  0 0 0 0 0 0 fd 1 1
6 0 0 0 0 0 0 c000 00 c0 6a 71  0 0 0 0 0 0 ff 1 1
6 0 0 1 1 0 0 c000 00 c0 6a 72  0 0 0 0 0 0 ff 1 1
6 0 0 0 1 0 0 9000 44 c0 6a 73  0 0 0 0 0 1 ff 1 1
6 0 0 0 0 0 0 0000 00 c0 6a 74  0 0 0 0 0 0 ff 1 1

//--- src.f
+incdir+include
design/sys_bus_pkg.sv
design/bus_capture.sv
design/addr_decode.sv
design/boot_ctrl.sv
design/rdata_return.sv
design/sys_decode_top.sv
dv/sys_decode_checker.sv
dv/sys_decode_monitor.sv
dv/sys_decode_tb.sv

//--- Bender.yml
package:
  name: sys_decode

sources:
  - include_dirs:
      - include
    files:
      - design/sys_bus_pkg.sv
      - design/bus_capture.sv
      - design/addr_decode.sv
      - design/boot_ctrl.sv
      - design/rdata_return.sv
      - design/sys_decode_top.sv
  - target: simulation
    files:
      - dv/sys_decode_checker.sv
      - dv/sys_decode_monitor.sv
      - dv/sys_decode_tb.sv
